// ==== source/cache_pkg.sv ====
package cache_pkg;

  ////////////////////////////////////////
  // Geometry shared by both levels
  ////////////////////////////////////////

  // Every level moves whole blocks of this many bytes
  parameter int block_bytes = 64;

  // Low address bits that select a byte inside a block
  parameter int offset_bits = $clog2(block_bytes);

  ////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////

  // Byte address as it arrives with a request
  typedef logic [31:0] addr_t;

  // Block number, the address with its offset stripped
  // Each level takes its set index from the low bits of this value
  typedef logic [31-offset_bits:0] tag_t;

  // One statistics counter, wraps at full width
  typedef logic [15:0] count_t;

  typedef enum logic {
    replace_fifo = 1'b0,
    replace_lru  = 1'b1
  } replace_policy_t;

  typedef enum logic {
    write_through = 1'b0,
    write_back    = 1'b1
  } write_policy_t;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } cache_op_t;

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  typedef struct packed {
    replace_policy_t replace_policy;
    write_policy_t   write_policy;
  } cache_cfg_t;

  typedef struct packed {
    addr_t     addr;
    cache_op_t op;
  } cache_req_t;

  // The L2 flag is only set when L1 missed and L2 then hit
  typedef struct packed {
    logic hit_l1;
    logic hit_l2;
  } cache_resp_t;

  typedef struct packed {
    count_t reads;
    count_t hits;
    count_t misses;
    count_t writes;
  } level_stats_t;

  // Summary of one finished request, handed to the counters
  typedef struct packed {
    cache_op_t op;
    logic      hit_l1;
    logic      l2_looked;
    logic      hit_l2;
  } access_event_t;

endpackage

// ==== source/tag_set_store.sv ====
`timescale 1ns/1ps

module tag_set_store #(
  parameter int num_sets = 8,
  parameter int assoc = 4
) (
  input  logic                     clk,
  input  logic                     reset,
  input  cache_pkg::tag_t          lookup_tag,
  output logic                     hit,
  output logic [$clog2(assoc)-1:0] hit_way,
  input  logic                     update,
  input  logic [$clog2(assoc)-1:0] promote
);

  localparam int index_bits = $clog2(num_sets);
  localparam int way_bits = $clog2(assoc);

  // Each set is an ordered list, way 0 holds the newest entry
  // and way assoc-1 holds the one that goes out next
  cache_pkg::tag_t tags [num_sets][assoc];

  // Valid bits replace the old habit of treating a zero tag as empty
  logic [num_sets-1:0][assoc-1:0] valid;

  logic [index_bits-1:0] set_idx;

  // The set index is simply the low bits of the block number
  assign set_idx = lookup_tag[index_bits-1:0];

  ////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////

  // Compare every way of the indexed set at once
  // Walking downward lets the lowest matching way win
  always_comb begin
    hit = 1'b0;
    hit_way = '0;
    for (int w = assoc - 1; w >= 0; w--) begin
      if (valid[set_idx][w] && (tags[set_idx][w] == lookup_tag)) begin
        hit = 1'b1;
        hit_way = way_bits'(w);
      end
    end
  end

  ////////////////////////////////////////
  // Ordered-list update
  ////////////////////////////////////////

  // Ways 0 to promote-1 move one place toward the old end, so the
  // entry sitting at promote is overwritten and thereby dropped
  // Ways above promote keep their place
  always_ff @(posedge clk) begin
    if (update) begin
      for (int w = 1; w < assoc; w++) begin
        if (way_bits'(w) <= promote) begin
          tags[set_idx][w] <= tags[set_idx][w-1];
        end
      end
      // The requested block always lands at the newest position
      tags[set_idx][0] <= lookup_tag;
    end
  end

  // Valid bits follow the same shift as the tags
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (update) begin
      for (int w = 1; w < assoc; w++) begin
        if (way_bits'(w) <= promote) begin
          valid[set_idx][w] <= valid[set_idx][w-1];
        end
      end
      valid[set_idx][0] <= 1'b1;
    end
  end

  // A promote past the last way would leave the old entry in place
  // while still inserting the new one, giving two copies of a block
  // The controller only ever sends way numbers taken from this store
  // or the fixed last way, so that case cannot come up

endmodule

// ==== source/hierarchy_controller.sv ====
`timescale 1ns/1ps

module hierarchy_controller #(
  parameter int l1_assoc = 4,
  parameter int l2_assoc = 8
) (
  input  logic                        clk,
  input  logic                        reset,
  input  cache_pkg::cache_cfg_t       cfg,
  input  logic                        req_valid,
  output logic                        req_ready,
  input  cache_pkg::cache_req_t       req,
  output logic                        resp_valid,
  input  logic                        resp_ready,
  output cache_pkg::cache_resp_t      resp,
  output cache_pkg::tag_t             lookup_tag,
  input  logic                        l1_hit,
  input  logic [$clog2(l1_assoc)-1:0] l1_hit_way,
  input  logic                        l2_hit,
  input  logic [$clog2(l2_assoc)-1:0] l2_hit_way,
  output logic                        l1_update,
  output logic [$clog2(l1_assoc)-1:0] l1_promote,
  output logic                        l2_update,
  output logic [$clog2(l2_assoc)-1:0] l2_promote,
  output logic                        event_valid,
  output cache_pkg::access_event_t    access_event
);

  localparam int l1_way_bits = $clog2(l1_assoc);
  localparam int l2_way_bits = $clog2(l2_assoc);

  typedef enum logic [1:0] {
    idle,
    l1_lookup,
    l2_lookup,
    respond
  } state_t;

  state_t state;

  // Request and replacement policy held for the whole transaction
  cache_pkg::cache_req_t req_q;
  cache_pkg::replace_policy_t replace_q;

  // Lookup results, registered per level
  logic l1_hit_q;
  logic l2_hit_q;
  logic l2_looked_q;
  logic [l1_way_bits-1:0] l1_way_q;
  logic [l2_way_bits-1:0] l2_way_q;

  // First cycle in respond, where the stores and counters commit
  logic finish;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      resp_valid <= 1'b0;
      l1_hit_q <= 1'b0;
      l2_hit_q <= 1'b0;
      l2_looked_q <= 1'b0;
    end else begin
      case (state)
        idle: if (req_valid) state <= l1_lookup;
        l1_lookup: begin
          l1_hit_q <= l1_hit;
          l2_hit_q <= 1'b0;
          l2_looked_q <= 1'b0;
          // L2 is only consulted when L1 misses
          state <= l1_hit ? respond : l2_lookup;
        end
        l2_lookup: begin
          l2_hit_q <= l2_hit;
          l2_looked_q <= 1'b1;
          state <= respond;
        end
        respond: begin
          // Raise the response on the commit edge, then wait for the taker
          if (!resp_valid) begin
            resp_valid <= 1'b1;
          end else if (resp_ready) begin
            resp_valid <= 1'b0;
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Payload captures
  always_ff @(posedge clk) begin
    if (state == idle && req_valid) begin
      req_q <= req;
      replace_q <= cfg.replace_policy;
    end
    if (state == l1_lookup) l1_way_q <= l1_hit_way;
    if (state == l2_lookup) l2_way_q <= l2_hit_way;
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign req_ready = (state == idle);
  assign finish = (state == respond) && !resp_valid;

  // Both stores see the same block number
  assign lookup_tag = req_q.addr[$bits(cache_pkg::addr_t)-1:cache_pkg::offset_bits];

  assign resp.hit_l1 = l1_hit_q;
  assign resp.hit_l2 = l2_hit_q;

  // A FIFO hit leaves the list alone, an LRU hit moves the way to the
  // front and a miss pushes out the oldest way
  assign l1_update = finish && !(l1_hit_q && replace_q == cache_pkg::replace_fifo);
  assign l1_promote = l1_hit_q ? l1_way_q : l1_way_bits'(l1_assoc - 1);
  assign l2_update = finish && l2_looked_q &&
                     !(l2_hit_q && replace_q == cache_pkg::replace_fifo);
  assign l2_promote = l2_hit_q ? l2_way_q : l2_way_bits'(l2_assoc - 1);

  assign event_valid = finish;
  assign access_event.op = req_q.op;
  assign access_event.hit_l1 = l1_hit_q;
  assign access_event.l2_looked = l2_looked_q;
  assign access_event.hit_l2 = l2_hit_q;

endmodule

// ==== source/access_counters.sv ====
`timescale 1ns/1ps

module access_counters (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       event_valid,
  input  cache_pkg::access_event_t   access_event,
  input  cache_pkg::write_policy_t   write_policy,
  output cache_pkg::level_stats_t    l1_stats,
  output cache_pkg::level_stats_t    l2_stats
);

  logic is_write;

  assign is_write = (access_event.op == cache_pkg::op_write);

  always_ff @(posedge clk) begin
    if (reset) begin
      l1_stats <= '0;
      l2_stats <= '0;
    end else if (event_valid) begin
      // Every request is an L1 read
      l1_stats.reads <= l1_stats.reads + 1'b1;
      if (access_event.hit_l1) begin
        l1_stats.hits <= l1_stats.hits + 1'b1;
      end else begin
        l1_stats.misses <= l1_stats.misses + 1'b1;
      end

      // L2 only counts requests that reached it
      if (access_event.l2_looked) begin
        l2_stats.reads <= l2_stats.reads + 1'b1;
        if (access_event.hit_l2) begin
          l2_stats.hits <= l2_stats.hits + 1'b1;
        end else begin
          l2_stats.misses <= l2_stats.misses + 1'b1;
        end
      end

      // Write-through sends every write to both levels
      // Write-back only charges a level where the block was missing
      if (is_write) begin
        if (write_policy == cache_pkg::write_through) begin
          l1_stats.writes <= l1_stats.writes + 1'b1;
          l2_stats.writes <= l2_stats.writes + 1'b1;
        end else begin
          if (!access_event.hit_l1) l1_stats.writes <= l1_stats.writes + 1'b1;
          if (access_event.l2_looked && !access_event.hit_l2) begin
            l2_stats.writes <= l2_stats.writes + 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== source/cache_engine.sv ====
`timescale 1ns/1ps

module cache_engine (
  input  logic                     clk,
  input  logic                     reset,
  input  cache_pkg::cache_cfg_t    cfg,
  input  logic                     req_valid,
  output logic                     req_ready,
  input  cache_pkg::cache_req_t    req,
  output logic                     resp_valid,
  input  logic                     resp_ready,
  output cache_pkg::cache_resp_t   resp,
  output cache_pkg::level_stats_t  l1_stats,
  output cache_pkg::level_stats_t  l2_stats
);

  ////////////////////////////////////////
  // Geometry of the two levels
  ////////////////////////////////////////

  // Sizes in bytes, set counts follow from block size and ways
  localparam int l1_bytes = 2048;
  localparam int l1_assoc = 4;
  localparam int l1_num_sets = l1_bytes / (cache_pkg::block_bytes * l1_assoc);
  localparam int l2_bytes = 8192;
  localparam int l2_assoc = 8;
  localparam int l2_num_sets = l2_bytes / (cache_pkg::block_bytes * l2_assoc);

  cache_pkg::tag_t lookup_tag;
  logic l1_hit;
  logic l2_hit;
  logic [$clog2(l1_assoc)-1:0] l1_hit_way;
  logic [$clog2(l2_assoc)-1:0] l2_hit_way;
  logic l1_update;
  logic l2_update;
  logic [$clog2(l1_assoc)-1:0] l1_promote;
  logic [$clog2(l2_assoc)-1:0] l2_promote;
  logic event_valid;
  cache_pkg::access_event_t access_event;

  hierarchy_controller #(.l1_assoc(l1_assoc), .l2_assoc(l2_assoc)) controller (
    .clk, .reset, .cfg, .req_valid, .req_ready, .req, .resp_valid, .resp_ready, .resp,
    .lookup_tag, .l1_hit, .l1_hit_way, .l2_hit, .l2_hit_way,
    .l1_update, .l1_promote, .l2_update, .l2_promote, .event_valid, .access_event
  );

  tag_set_store #(.num_sets(l1_num_sets), .assoc(l1_assoc)) l1_store (
    .clk, .reset, .lookup_tag, .hit(l1_hit), .hit_way(l1_hit_way),
    .update(l1_update), .promote(l1_promote)
  );

  tag_set_store #(.num_sets(l2_num_sets), .assoc(l2_assoc)) l2_store (
    .clk, .reset, .lookup_tag, .hit(l2_hit), .hit_way(l2_hit_way),
    .update(l2_update), .promote(l2_promote)
  );

  // The write policy is read live, it only changes between requests
  access_counters counters (
    .clk, .reset, .event_valid, .access_event,
    .write_policy(cfg.write_policy), .l1_stats, .l2_stats
  );

endmodule

// ==== tb/cache_engine_asserts.sv ====
`timescale 1ns/1ps

module cache_engine_asserts (
  input logic                   clk,
  input logic                   reset,
  input logic                   req_ready,
  input logic                   resp_valid,
  input logic                   resp_ready,
  input cache_pkg::cache_resp_t resp
);

  // Number of assertion failures so far, watched from the testbench
  int failures = 0;

  // Only one request is ever in flight
  ready_while_busy: assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> !req_ready)
    else begin
      failures++;
      $error("req_ready is high while a response is pending");
    end

  // A stalled response keeps its payload
  resp_held: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && !resp_ready) |=> $stable(resp))
    else begin
      failures++;
      $error("resp changed while it was waiting to be taken");
    end

  // L2 is only consulted after an L1 miss
  hit_levels_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(resp.hit_l1 && resp.hit_l2))
    else begin
      failures++;
      $error("resp reports a hit in both levels");
    end

  no_resp_after_reset: assert property (@(posedge clk) reset |=> !resp_valid)
    else begin
      failures++;
      $error("resp_valid is high in the cycle after reset");
    end

endmodule

bind cache_engine cache_engine_asserts handshake_checks (
  .clk(clk), .reset(reset), .req_ready(req_ready), .resp_valid(resp_valid),
  .resp_ready(resp_ready), .resp(resp)
);

// ==== tb/cache_engine_tb.sv ====
`timescale 1ns/1ps

module cache_engine_tb;

  localparam int random_count = 400;
  localparam int write_count = 100;
  localparam int stall_count = 200;
  localparam int total_requests = 4 + 2 * random_count + 2 * write_count + stall_count;
  localparam int sets_of_level [2] = '{8, 16};
  localparam int ways_of_level [2] = '{4, 8};

  logic clk;
  logic reset;
  cache_pkg::cache_cfg_t cfg;
  logic req_valid;
  logic req_ready;
  cache_pkg::cache_req_t req;
  logic resp_valid;
  logic resp_ready;
  cache_pkg::cache_resp_t resp;
  cache_pkg::level_stats_t l1_stats;
  cache_pkg::level_stats_t l2_stats;

  // Reference copy of both levels
  // Way 0 of every set holds the newest entry
  cache_pkg::tag_t model_tag [2][16][8];
  bit model_valid [2][16][8];
  cache_pkg::level_stats_t model_stats [2];
  logic [31:0] lfsr;
  int req_count;

  cache_engine UUT (
    .clk, .reset, .cfg, .req_valid, .req_ready, .req,
    .resp_valid, .resp_ready, .resp, .l1_stats, .l2_stats
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Each request needs well under 20 cycles even with a stalled taker
  initial begin
    #(total_requests * 20 * 4);
    stop_with("Timeout: the DUT stopped answering requests");
  end

  // Failures of the bound handshake assertions end the run here
  initial begin
    forever begin
      @(negedge clk);
      assert (UUT.handshake_checks.failures == 0) else
        stop_with("A bound handshake assertion on the DUT failed");
    end
  end

  ////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////

  // Taps 32, 22, 2 and 1 with one step per bit handed out
  function automatic logic [31:0] random_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Blocks 0 to 31 with the low set bits random are the hot pool
  // A quarter of the requests reach out to 256 blocks and force evictions
  function automatic cache_pkg::cache_req_t random_request();
    cache_pkg::cache_req_t r;
    logic [4:0] hi;
    logic [2:0] lo;
    lo = 3'(random_bits(3));
    hi = (random_bits(2) == 0) ? 5'(random_bits(5)) : 5'(random_bits(2));
    r.addr = {18'd0, hi, lo, 6'(random_bits(6))};
    r.op = cache_pkg::cache_op_t'(random_bits(1));
    return r;
  endfunction

  function automatic logic ready_pick(bit stall);
    logic [31:0] b;
    if (!stall) return 1'b1;
    b = random_bits(1);
    return b[0];
  endfunction

  function automatic void clear_model();
    for (int l = 0; l < 2; l++)
      for (int s = 0; s < 16; s++)
        for (int w = 0; w < 8; w++) model_valid[l][s][w] = 1'b0;
    model_stats[0] = '0;
    model_stats[1] = '0;
  endfunction

  // Shift the newer entries down and put the block in front
  function automatic void move_to_front(int lvl, int s, cache_pkg::tag_t tag, int pos);
    for (int w = pos; w > 0; w--) begin
      model_tag[lvl][s][w] = model_tag[lvl][s][w-1];
      model_valid[lvl][s][w] = model_valid[lvl][s][w-1];
    end
    model_tag[lvl][s][0] = tag;
    model_valid[lvl][s][0] = 1'b1;
  endfunction

  // Look the block up in one level, count it and apply the replacement rule
  function automatic bit lookup_level(int lvl, cache_pkg::tag_t tag);
    int s;
    int way;
    s = int'(tag) % sets_of_level[lvl];
    way = -1;
    for (int w = ways_of_level[lvl] - 1; w >= 0; w--)
      if (model_valid[lvl][s][w] && model_tag[lvl][s][w] == tag) way = w;
    model_stats[lvl].reads = model_stats[lvl].reads + 16'd1;
    if (way >= 0) begin
      model_stats[lvl].hits = model_stats[lvl].hits + 16'd1;
      if (cfg.replace_policy == cache_pkg::replace_lru) move_to_front(lvl, s, tag, way);
    end else begin
      // The oldest way is the one that goes
      model_stats[lvl].misses = model_stats[lvl].misses + 16'd1;
      move_to_front(lvl, s, tag, ways_of_level[lvl] - 1);
    end
    return way >= 0;
  endfunction

  function automatic cache_pkg::cache_resp_t model_access(cache_pkg::cache_req_t r);
    cache_pkg::tag_t tag;
    cache_pkg::cache_resp_t e;
    bit through;
    tag = cache_pkg::tag_t'(r.addr >> cache_pkg::offset_bits);
    through = (cfg.write_policy == cache_pkg::write_through);
    e = '0;
    e.hit_l1 = lookup_level(0, tag);
    if (!e.hit_l1) e.hit_l2 = lookup_level(1, tag);
    if (r.op == cache_pkg::op_write) begin
      if (through || !e.hit_l1) model_stats[0].writes = model_stats[0].writes + 16'd1;
      if (through || (!e.hit_l1 && !e.hit_l2))
        model_stats[1].writes = model_stats[1].writes + 16'd1;
    end
    return e;
  endfunction

  ////////////////////////////////////////
  // Driving and checking
  ////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    req_valid = 1'b0;
    repeat (2) step();
    reset = 1'b0;
    clear_model();
  endtask

  // Full handshake for one request with latency and payload checked on the way
  task automatic run_request(input cache_pkg::cache_req_t r, input bit stall,
                             output cache_pkg::cache_resp_t got);
    cache_pkg::cache_resp_t expected;
    int cycles;
    expected = model_access(r);
    req_count++;
    req = r;
    req_valid = 1'b1;
    while (!req_ready) step();
    step();
    req_valid = 1'b0;
    cycles = 0;
    do begin
      resp_ready = ready_pick(stall);
      step();
      cycles++;
    end while (!resp_valid && cycles < 8);
    assert (cycles == (expected.hit_l1 ? 2 : 3)) else
      stop_with($sformatf("Mismatch at %0t ns: request %0d answered after %0d cycles",
                          $time, req_count, cycles));
    while (1'b1) begin
      assert (resp_valid && resp === expected) else
        stop_with($sformatf("Mismatch at %0t ns: request %0d to %h gave %b, expected %b",
                            $time, req_count, r.addr, resp, expected));
      if (resp_ready) break;
      step();
      resp_ready = ready_pick(stall);
    end
    got = resp;
    step();
    assert (!resp_valid) else
      stop_with($sformatf("Mismatch at %0t ns: request %0d answered twice", $time, req_count));
  endtask

  task automatic run_random(input int count, input bit stall);
    cache_pkg::cache_resp_t got;
    for (int i = 0; i < count; i++) run_request(random_request(), stall, got);
  endtask

  task automatic check_stats(input string phase);
    assert (l1_stats === model_stats[0] && l2_stats === model_stats[1]) else
      stop_with($sformatf("Mismatch at %0t ns: %s stats L1 %h L2 %h, expected L1 %h L2 %h",
                          $time, phase, l1_stats, l2_stats, model_stats[0], model_stats[1]));
    assert (l1_stats.reads == l1_stats.hits + l1_stats.misses) else
      stop_with($sformatf("Mismatch at %0t ns: %s L1 reads differ from hits plus misses",
                          $time, phase));
    assert (l2_stats.reads == l1_stats.misses) else
      stop_with($sformatf("Mismatch at %0t ns: %s L2 reads differ from L1 misses",
                          $time, phase));
  endtask

  initial begin
    cache_pkg::cache_req_t first;
    cache_pkg::cache_req_t cold;
    cache_pkg::cache_resp_t got;
    reset = 1'b1;
    req_valid = 1'b0;
    req = '0;
    resp_ready = 1'b1;
    cfg.replace_policy = cache_pkg::replace_lru;
    cfg.write_policy = cache_pkg::write_through;
    lfsr = 32'he466;
    req_count = 0;
    #1;
    apply_reset();
    assert (req_ready && !resp_valid) else stop_with("The DUT did not come out of reset idle");

    // A cold block misses twice, then sits in L1
    first.addr = 32'h0000_1a40;
    first.op = cache_pkg::op_read;
    run_request(first, 1'b0, got);
    assert (got == 2'b00) else
      stop_with($sformatf("Mismatch at %0t ns: cold request gave %b", $time, got));
    run_request(first, 1'b0, got);
    assert (got == 2'b10) else
      stop_with($sformatf("Mismatch at %0t ns: repeated request gave %b", $time, got));

    run_random(random_count, 1'b0);
    check_stats("LRU");
    cfg.replace_policy = cache_pkg::replace_fifo;
    run_random(random_count, 1'b0);
    check_stats("FIFO");

    cfg.replace_policy = cache_pkg::replace_lru;
    run_random(write_count, 1'b0);
    check_stats("write-through");
    cfg.write_policy = cache_pkg::write_back;
    run_random(write_count, 1'b0);
    check_stats("write-back");

    // The taker now drops resp_ready at random
    run_random(stall_count, 1'b1);
    check_stats("stalled");

    // A block outside the random pool misses cold and so lands in both levels
    // Then a reset has to forget it in both
    cold.addr = 32'h0001_2340;
    cold.op = cache_pkg::op_read;
    run_request(cold, 1'b0, got);
    assert (got == 2'b00) else
      stop_with($sformatf("Mismatch at %0t ns: unused block gave %b", $time, got));
    apply_reset();
    assert (l1_stats == '0 && l2_stats == '0) else
      stop_with($sformatf("Mismatch at %0t ns: counters not cleared by reset", $time));
    run_request(cold, 1'b0, got);
    assert (got == 2'b00) else
      stop_with($sformatf("Mismatch at %0t ns: block survived reset, got %b", $time, got));
    check_stats("after reset");

    if (UUT.handshake_checks.failures == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_with("A bound handshake assertion on the DUT failed");
    end
  end

endmodule

// ==== tb.f ====
source/cache_pkg.sv
source/tag_set_store.sv
source/hierarchy_controller.sv
source/access_counters.sv
source/cache_engine.sv
tb/cache_engine_asserts.sv
tb/cache_engine_tb.sv

// ==== Makefile ====
# Verilator build and run of the cache hierarchy testbench

VERILATOR  ?= verilator
TOP        ?= cache_engine_tb
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
SIM_ARGS   ?= +verilator+error+limit+100
FAIL_MSG   ?= STATUS: FAIL
PASS_MSG   ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
